/* logic/rv_pkg.sv */
package rv_pkg;

    localparam int mem_words = 1024;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [$clog2(mem_words)-1:0] mem_addr_t;
    typedef logic [2:0]  alu_ctrl_t;

    localparam alu_ctrl_t alu_add = 3'd0;
    localparam alu_ctrl_t alu_sub = 3'd1;
    localparam alu_ctrl_t alu_and = 3'd2;
    localparam alu_ctrl_t alu_or  = 3'd3;
    localparam alu_ctrl_t alu_xor = 3'd4;
    localparam alu_ctrl_t alu_slt = 3'd5;

    localparam logic [1:0] aluop_add  = 2'b00; // Address and pc arithmetic
    localparam logic [1:0] aluop_sub  = 2'b01; // Branch compare
    localparam logic [1:0] aluop_func = 2'b10; // From funct3/funct7

    localparam logic [1:0] srcb_reg    = 2'b00;
    localparam logic [1:0] srcb_four   = 2'b01;
    localparam logic [1:0] srcb_imm    = 2'b10; // I, S or U immediate
    localparam logic [1:0] srcb_offset = 2'b11; // B or J offset

    localparam logic [1:0] pcsrc_alu     = 2'b00;
    localparam logic [1:0] pcsrc_alu_out = 2'b01;

    localparam opcode_t op_r      = 7'b0110011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_system = 7'b1110011;

    typedef struct packed {
        logic       pc_write_cond;
        logic       pc_write;
        logic       iord;
        logic       memory_read;
        logic       memory_write;
        logic       memory_to_reg;
        logic       ir_write;
        logic [1:0] pc_source;
        logic [1:0] alu_op;
        logic [1:0] alu_src_b;
        logic       alu_src_a;     // 0 old pc, 1 register A
        logic       reg_write;
        logic       branch_ne;
    } ctrl_t;

    typedef struct packed {
        mem_addr_t addr;
        word_t     wdata;
        logic      we;
        logic      re;
    } mem_req_t;

    typedef enum logic [3:0] {
        idle, fetch, fetch_wait, decode, execute, mem_addr, mem_read,
        mem_wait, mem_write, alu_writeback, branch, jump, halt
    } state_t;

endpackage

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
    input  rv_pkg::word_t     a,
    input  rv_pkg::word_t     b,
    input  rv_pkg::alu_ctrl_t op,
    output rv_pkg::word_t     result,
    output logic              zero
);
    import rv_pkg::*;

    logic lt;

    assign lt = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_slt: result = {31'b0, lt};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0); // Used by beq/bne

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic              clk,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::word_t     wdata,
    input  logic              we,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2
);
    import rv_pkg::*;

    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* logic/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_pkg::opcode_t opcode,
    input  logic            funct3_lsb,
    input  logic            zero,
    input  logic            core_grant,
    input  logic            run,
    output rv_pkg::ctrl_t   ctrl,
    output logic            halted
);
    import rv_pkg::*;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle:       if (run) next_state = fetch;
            fetch:      if (core_grant) next_state = fetch_wait;
            fetch_wait: next_state = decode;
            decode: begin
                case (opcode)
                    op_r, op_imm, op_lui: next_state = execute;
                    op_load, op_store:    next_state = mem_addr;
                    op_branch:            next_state = branch;
                    op_jal:               next_state = jump;
                    op_system:            next_state = halt; // ecall
                    default:              next_state = halt;
                endcase
            end
            execute:    next_state = alu_writeback;
            mem_addr:   next_state = (opcode == op_load) ? mem_read : mem_write;
            mem_read:   if (core_grant) next_state = mem_wait;
            mem_write:  if (core_grant) next_state = fetch;
            mem_wait, alu_writeback, branch, jump: begin
                next_state = fetch;
            end
            halt:       next_state = halt;
            default:    next_state = idle;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (state)
            fetch: begin
                ctrl.memory_read = 1'b1; // iord low, address from pc
            end
            fetch_wait: begin
                ctrl.ir_write  = 1'b1;
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = pcsrc_alu;
                ctrl.alu_src_b = srcb_four;
                ctrl.alu_op    = aluop_add;
            end
            decode: begin
                ctrl.alu_src_b = srcb_offset; // Branch or jump target into ALUOut
                ctrl.alu_op    = aluop_add;
            end
            execute: begin
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_src_b = (opcode == op_r) ? srcb_reg : srcb_imm;
                ctrl.alu_op    = (opcode == op_lui) ? aluop_add : aluop_func;
            end
            alu_writeback: begin
                ctrl.reg_write = 1'b1;
            end
            mem_addr: begin
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_src_b = srcb_imm;
                ctrl.alu_op    = aluop_add;
            end
            mem_read: begin
                ctrl.iord        = 1'b1;
                ctrl.memory_read = 1'b1;
            end
            mem_wait: begin
                ctrl.reg_write     = 1'b1;
                ctrl.memory_to_reg = 1'b1;
            end
            mem_write: begin
                ctrl.iord         = 1'b1;
                ctrl.memory_write = 1'b1;
            end
            branch: begin
                ctrl.alu_src_a     = 1'b1;
                ctrl.alu_src_b     = srcb_reg;
                ctrl.alu_op        = aluop_sub;
                ctrl.pc_write_cond = 1'b1;
                ctrl.branch_ne     = funct3_lsb;
                ctrl.pc_source     = pcsrc_alu_out;
            end
            jump: begin
                ctrl.pc_write  = 1'b1; // With reg_write, rd takes the link address
                ctrl.pc_source = pcsrc_alu_out;
                ctrl.reg_write = 1'b1;
            end
            default: ctrl = '0; // idle and halt
        endcase
    end

    assign halted = (state == halt);

endmodule

/* logic/datapath.sv */
`timescale 1ns/1ps

module datapath (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::ctrl_t    ctrl,
    input  rv_pkg::word_t    core_rdata,
    output rv_pkg::mem_req_t core_req,
    output rv_pkg::opcode_t  opcode,
    output logic             funct3_lsb,
    output logic             zero
);
    import rv_pkg::*;

    word_t     pc;
    word_t     old_pc;
    word_t     ir;
    word_t     a_reg;
    word_t     b_reg;
    word_t     alu_out;
    word_t     rdata1;
    word_t     rdata2;
    word_t     reg_wdata;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_b;
    word_t     imm_u;
    word_t     imm_j;
    word_t     imm_sel;
    word_t     imm_rel;
    word_t     src_a;
    word_t     src_b;
    word_t     alu_result;
    alu_ctrl_t alu_ctrl;
    logic      pc_en;

    assign opcode     = ir[6:0];
    assign funct3_lsb = ir[12];

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {ir[31:12], 12'b0};
    assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    assign imm_sel = (opcode == op_store) ? imm_s :
                     (opcode == op_lui)   ? imm_u : imm_i;
    assign imm_rel = (opcode == op_jal) ? imm_j : imm_b;

    // lui adds its immediate to zero
    assign src_a = ctrl.alu_src_a ? ((opcode == op_lui) ? '0 : a_reg) : old_pc;

    always_comb begin
        case (ctrl.alu_src_b)
            srcb_reg:  src_b = b_reg;
            srcb_four: src_b = 32'd4;
            srcb_imm:  src_b = imm_sel;
            default:   src_b = imm_rel;
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            aluop_sub: alu_ctrl = alu_sub;
            aluop_func: begin
                case (ir[14:12])
                    3'b000:  alu_ctrl = (opcode == op_r && ir[30]) ? alu_sub : alu_add;
                    3'b010:  alu_ctrl = alu_slt;
                    3'b100:  alu_ctrl = alu_xor;
                    3'b110:  alu_ctrl = alu_or;
                    3'b111:  alu_ctrl = alu_and;
                    default: alu_ctrl = alu_add;
                endcase
            end
            default: alu_ctrl = alu_add;
        endcase
    end

    alu i_alu (
        .a      (src_a),
        .b      (src_b),
        .op     (alu_ctrl),
        .result (alu_result),
        .zero   (zero)
    );

    // Registered memory output stands in for the MDR
    assign reg_wdata = ctrl.memory_to_reg ? core_rdata :
                       ctrl.pc_write      ? pc : alu_out; // jal link is pc + 4

    register_file i_register_file (
        .clk    (clk),
        .rs1    (ir[19:15]),
        .rs2    (ir[24:20]),
        .rd     (ir[11:7]),
        .wdata  (reg_wdata),
        .we     (ctrl.reg_write),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    assign pc_en = ctrl.pc_write | (ctrl.pc_write_cond & (zero ^ ctrl.branch_ne));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= '0;
            old_pc  <= '0;
            ir      <= '0;
            a_reg   <= '0;
            b_reg   <= '0;
            alu_out <= '0;
        end else begin
            if (pc_en) begin
                pc <= (ctrl.pc_source == pcsrc_alu_out) ? alu_out : alu_result;
            end
            if (ctrl.memory_read && !ctrl.iord) begin
                old_pc <= pc; // Address of the instruction being fetched
            end
            if (ctrl.ir_write) begin
                ir <= core_rdata;
            end
            if (!ctrl.iord) begin
                alu_out <= alu_result; // Held while a data access waits
            end
            a_reg <= rdata1;
            b_reg <= rdata2;
        end
    end

    assign core_req.addr  = ctrl.iord ? alu_out[$bits(mem_addr_t)+1:2]
                                      : pc[$bits(mem_addr_t)+1:2];
    assign core_req.wdata = b_reg;
    assign core_req.we    = ctrl.memory_write;
    assign core_req.re    = ctrl.memory_read;

endmodule

/* logic/memory_arbiter.sv */
`timescale 1ns/1ps

module memory_arbiter (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::mem_req_t host_req,
    input  rv_pkg::mem_req_t core_req,
    input  rv_pkg::word_t    mem_rdata,
    output rv_pkg::mem_req_t mem_req,
    output logic             core_grant,
    output rv_pkg::word_t    host_rdata,
    output rv_pkg::word_t    core_rdata
);
    import rv_pkg::*;

    logic  core_owned;
    logic  host_read_q;
    word_t host_hold;

    // Host always wins
    assign core_grant = !(host_req.we || host_req.re);
    assign mem_req    = core_grant ? core_req : host_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            core_owned  <= 1'b0;
            host_read_q <= 1'b0;
        end else begin
            core_owned  <= core_grant;
            host_read_q <= host_req.re;
        end
    end

    always_ff @(posedge clk) begin
        if (host_read_q) begin
            host_hold <= mem_rdata;
        end
    end

    assign host_rdata = host_read_q ? mem_rdata : host_hold;
    assign core_rdata = core_owned ? mem_rdata : '0;

endmodule

/* logic/unified_memory.sv */
`timescale 1ns/1ps

module unified_memory (
    input  logic             clk,
    input  rv_pkg::mem_req_t req,
    output rv_pkg::word_t    rdata
);
    import rv_pkg::*;

    word_t mem [mem_words];

    always_ff @(posedge clk) begin
        if (req.we) begin
            mem[req.addr] <= req.wdata;
        end
        if (req.re) begin
            rdata <= mem[req.addr]; // One cycle read
        end
    end

endmodule

/* logic/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             run,
    input  rv_pkg::mem_req_t host_req,
    output rv_pkg::word_t    host_rdata,
    output logic             halted
);
    import rv_pkg::*;

    ctrl_t    ctrl;
    mem_req_t core_req;
    mem_req_t mem_req;
    word_t    core_rdata;
    word_t    mem_rdata;
    opcode_t  opcode;
    logic     funct3_lsb;
    logic     zero;
    logic     core_grant;

    control_unit i_control_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .opcode     (opcode),
        .funct3_lsb (funct3_lsb),
        .zero       (zero),
        .core_grant (core_grant),
        .run        (run),
        .ctrl       (ctrl),
        .halted     (halted)
    );

    datapath i_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .core_rdata (core_rdata),
        .core_req   (core_req),
        .opcode     (opcode),
        .funct3_lsb (funct3_lsb),
        .zero       (zero)
    );

    memory_arbiter i_memory_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_req   (host_req),
        .core_req   (core_req),
        .mem_rdata  (mem_rdata),
        .mem_req    (mem_req),
        .core_grant (core_grant),
        .host_rdata (host_rdata),
        .core_rdata (core_rdata)
    );

    unified_memory i_unified_memory (
        .clk   (clk),
        .req   (mem_req),
        .rdata (mem_rdata)
    );

endmodule

/* verification/rv_core_properties.sv */
`timescale 1ns/1ps

module rv_core_properties (
    input logic           clk,
    input logic           rst_n,
    input rv_pkg::state_t state,
    input rv_pkg::ctrl_t  ctrl,
    input logic           core_grant,
    input logic           halted
);
    import rv_pkg::*;

    int unsigned failures = 0;

    read_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.memory_read && ctrl.memory_write))
    else begin
        failures++;
        $error("memory_read and memory_write are both set");
    end

    // No grant, no progress
    stall_holds_state: assert property (@(posedge clk) disable iff (!rst_n)
        (state inside {fetch, mem_read, mem_write} && !core_grant) |=> state == $past(state))
    else begin
        failures++;
        $error("state left a memory state without core_grant");
    end

    halted_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
    else begin
        failures++;
        $error("halted dropped without reset");
    end

    idle_ctrl_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (state == idle) |-> (ctrl == '0))
    else begin
        failures++;
        $error("ctrl is not zero in idle");
    end

endmodule

bind control_unit rv_core_properties i_rv_core_properties (
    .clk        (clk),
    .rst_n      (rst_n),
    .state      (state),
    .ctrl       (ctrl),
    .core_grant (core_grant),
    .halted     (halted)
);

/* verification/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;
    import rv_pkg::*;

    localparam int data_base  = 512;
    localparam int data_words = 64;
    localparam int host_lo    = 600;
    localparam int host_hi    = 700;
    localparam int wait_limit = 2000;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     run;
    mem_req_t host_req;
    word_t    host_rdata;
    logic     halted;

    word_t lfsr_state = 32'h972e;
    word_t prog [128];
    int    prog_len;
    word_t image [mem_words];     // Everything the host has written
    word_t model_mem [mem_words];
    word_t shadow [host_lo:host_hi];

    rv_core_top i_rv_core_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .host_req   (host_req),
        .host_rdata (host_rdata),
        .halted     (halted)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (i_rv_core_top.i_control_unit.i_rv_core_properties.failures != 0) begin
            $display("Simulation finished: FAIL");
            $fatal(1, "an assertion bound to control_unit failed");
        end
    end

    function automatic word_t rand_bits(input int n);
        word_t value;
        logic  fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic reg_addr_t rand_rs();
        word_t v;
        v = rand_bits(3);
        return v[4:0]; // x0 to x7
    endfunction

    function automatic reg_addr_t rand_rd();
        reg_addr_t r;
        r = rand_rs();
        return (r == 5'd0) ? 5'd1 : r;
    endfunction

    function automatic word_t enc_r(input word_t f7, input reg_addr_t rs2, input reg_addr_t rs1,
                                    input word_t f3, input reg_addr_t rd);
        return {f7[6:0], rs2, rs1, f3[2:0], rd, op_r};
    endfunction

    function automatic word_t enc_i(input word_t imm, input reg_addr_t rs1, input word_t f3,
                                    input reg_addr_t rd, input opcode_t op);
        return {imm[11:0], rs1, f3[2:0], rd, op};
    endfunction

    function automatic word_t enc_s(input word_t imm, input reg_addr_t rs2, input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic word_t enc_b(input word_t off, input reg_addr_t rs2, input reg_addr_t rs1,
                                    input logic ne);
        return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], op_branch};
    endfunction

    function automatic word_t enc_j(input word_t off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    function automatic word_t arith_ins();
        word_t     sel;
        word_t     u;
        reg_addr_t rd;
        sel = rand_bits(3);
        rd  = rand_rd();
        case (sel)
            0: return enc_r('h00, rand_rs(), rand_rs(), 0, rd);
            1: return enc_r('h20, rand_rs(), rand_rs(), 0, rd); // sub
            2: return enc_r('h00, rand_rs(), rand_rs(), 7, rd);
            3: return enc_r('h00, rand_rs(), rand_rs(), 6, rd);
            4: return enc_r('h00, rand_rs(), rand_rs(), 4, rd);
            5: return enc_r('h00, rand_rs(), rand_rs(), 2, rd);
            6: return enc_i(rand_bits(12), rand_rs(), 0, rd, op_imm);
            default: begin
                u = rand_bits(20);
                return {u[19:0], rd, op_lui};
            end
        endcase
    endfunction

    function automatic word_t mem_ins();
        word_t sel;
        word_t off;
        sel = rand_bits(2);
        off = rand_bits(6) << 2; // Stays inside the data region
        case (sel)
            0:       return enc_i(off, 5'd8, 2, rand_rd(), op_load);
            1, 2:    return enc_s(off, rand_rs(), 5'd8);
            default: return arith_ins();
        endcase
    endfunction

    // kind 0 arithmetic, 1 load/store, 2 branch and jal, 3 all of them
    task automatic gen_program(input int kind, input logic end_unknown);
        int        n;
        int        body_end;
        int        pick;
        int        skip;
        word_t     sel;
        word_t     coin;
        reg_addr_t rs1;
        reg_addr_t rs2;
        prog[0] = enc_i(1024, 5'd0, 0, 5'd8, op_imm);
        prog[1] = enc_i(1024, 5'd8, 0, 5'd8, op_imm); // x8 points at word 512
        for (int r = 1; r < 8; r++) begin
            prog[r + 1] = enc_i(rand_bits(12), 5'd0, 0, reg_addr_t'(r), op_imm);
        end
        n        = 9;
        body_end = n + 24 + int'(rand_bits(4));
        while (n < body_end) begin
            pick = (kind == 3) ? int'(rand_bits(2) % 3) : kind;
            if (pick == 0) begin
                prog[n] = arith_ins();
            end else if (pick == 1) begin
                prog[n] = mem_ins();
            end else begin
                sel  = rand_bits(2);
                skip = rand_bits(2);
                if (n + 1 + skip > body_end) skip = body_end - n - 1; // Never past the stores
                if (sel == 0) begin
                    coin    = rand_bits(1);
                    rs1     = rand_rs();
                    rs2     = coin[0] ? rs1 : rand_rs();
                    coin    = rand_bits(1);
                    prog[n] = enc_b(word_t'((skip + 1) * 4), rs2, rs1, coin[0]);
                end else if (sel == 1) begin
                    prog[n] = enc_j(word_t'((skip + 1) * 4), rand_rd());
                end else begin
                    prog[n] = arith_ins();
                end
            end
            n++;
        end
        for (int r = 1; r < 8; r++) begin
            prog[n] = enc_s(word_t'((56 + r) * 4), reg_addr_t'(r), 5'd8);
            n++;
        end
        prog[n]  = end_unknown ? 32'h0000000b : 32'h00000073;
        prog_len = n + 1;
    endtask

    task automatic run_model();
        word_t regs [32];
        word_t pc;
        word_t next_pc;
        word_t ins;
        word_t a;
        word_t b;
        word_t addr;
        word_t res;
        logic  wr;
        logic  done;
        int    steps;
        model_mem = image;
        foreach (regs[i]) regs[i] = '0;
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            ins     = model_mem[pc[11:2]];
            a       = regs[ins[19:15]];
            b       = regs[ins[24:20]];
            next_pc = pc + 4;
            wr      = 1'b1;
            res     = '0;
            case (ins[6:0])
                op_r: begin
                    case (ins[14:12])
                        3'b000:  res = ins[30] ? a - b : a + b;
                        3'b010:  res = word_t'($signed(a) < $signed(b));
                        3'b100:  res = a ^ b;
                        3'b110:  res = a | b;
                        default: res = a & b;
                    endcase
                end
                op_imm: res = a + {{20{ins[31]}}, ins[31:20]};
                op_lui: res = {ins[31:12], 12'b0};
                op_load: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    res  = model_mem[addr[11:2]];
                end
                op_store: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    model_mem[addr[11:2]] = b;
                    wr = 1'b0;
                end
                op_branch: begin
                    wr = 1'b0;
                    if ((a == b) != ins[12]) begin
                        next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                op_jal: begin
                    res     = pc + 4;
                    next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                default: begin
                    wr   = 1'b0;
                    done = 1'b1; // ecall or unknown opcode
                end
            endcase
            if (wr && ins[11:7] != 5'd0) regs[ins[11:7]] = res;
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic compare_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "level mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        rst_n    = 1'b0;
        run      = 1'b0;
        host_req = '0;
        repeat (4) next_cycle();
        rst_n = 1'b1;
    endtask

    task automatic host_write(input int addr, input word_t data);
        host_req.addr  = mem_addr_t'(addr);
        host_req.wdata = data;
        host_req.we    = 1'b1;
        host_req.re    = 1'b0;
        next_cycle();
        host_req    = '0;
        image[addr] = data;
    endtask

    task automatic host_read(input int addr, output word_t data);
        host_req.addr = mem_addr_t'(addr);
        host_req.we   = 1'b0;
        host_req.re   = 1'b1;
        next_cycle();
        host_req = '0;
        data     = host_rdata; // Valid in the cycle after the request
    endtask

    task automatic wait_halted(input string name, input logic traffic);
        int    cycles;
        int    addr;
        word_t sel;
        word_t expected;
        logic  pending;
        cycles  = 0;
        pending = 1'b0;
        while (!halted && cycles < wait_limit) begin
            if (pending) compare_word({name, " host read"}, expected, host_rdata);
            pending  = 1'b0;
            host_req = '0;
            if (traffic) begin
                sel  = rand_bits(2);
                addr = host_lo + int'(rand_bits(7) % 101);
                host_req.addr = mem_addr_t'(addr);
                if (sel == 1) begin
                    host_req.wdata = rand_bits(32);
                    host_req.we    = 1'b1;
                    shadow[addr]   = host_req.wdata;
                end else if (sel == 2) begin
                    host_req.re = 1'b1;
                    expected    = shadow[addr];
                    pending     = 1'b1;
                end
            end
            next_cycle();
            cycles++;
        end
        host_req = '0;
        if (pending) compare_word({name, " host read"}, expected, host_rdata);
        if (!halted) begin
            $display("Timeout in %s: the core did not halt within %0d cycles", name, wait_limit);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    endtask

    task automatic check_memory(input string name);
        word_t d;
        for (int a = 0; a < prog_len; a++) begin
            host_read(a, d);
            compare_word($sformatf("%s program word %0d", name, a), model_mem[a], d);
        end
        for (int a = data_base; a < data_base + data_words; a++) begin
            host_read(a, d);
            compare_word($sformatf("%s data word %0d", name, a), model_mem[a], d);
        end
    endtask

    task automatic check_idle_host();
        word_t d;
        apply_reset();
        for (int a = data_base; a < data_base + data_words; a++) begin
            host_write(a, rand_bits(32));
            host_read(a, d);
            compare_word($sformatf("idle readback word %0d", a), image[a], d);
            compare_level("idle halted", 1'b0, halted);
        end
    endtask

    task automatic run_program(input string name, input int kind, input logic end_unknown,
                               input logic traffic);
        word_t d;
        apply_reset();
        compare_level({name, " halted after reset"}, 1'b0, halted);
        gen_program(kind, end_unknown);
        for (int a = 0; a < prog_len; a++) host_write(a, prog[a]);
        for (int a = data_base; a < data_base + data_words; a++) host_write(a, rand_bits(32));
        if (traffic) begin
            for (int a = host_lo; a <= host_hi; a++) begin
                d = rand_bits(32);
                host_write(a, d);
                shadow[a] = d;
            end
        end
        run_model();
        run = 1'b1;
        wait_halted(name, traffic);
        repeat (50) begin // Halt must hold with memory left alone
            compare_level({name, " halted hold"}, 1'b1, halted);
            next_cycle();
        end
        check_memory(name);
    endtask

    initial begin
        rst_n    = 1'b0;
        run      = 1'b0;
        host_req = '0;
        check_idle_host();
        repeat (3) run_program("arith", 0, 1'b0, 1'b0);
        repeat (3) run_program("load_store", 1, 1'b0, 1'b0);
        repeat (4) run_program("branch_jal", 2, 1'b0, 1'b0);
        repeat (2) run_program("host_traffic", 3, 1'b0, 1'b1);
        run_program("ecall_halt", 3, 1'b0, 1'b0);
        run_program("unknown_opcode", 3, 1'b1, 1'b0);
        if (i_rv_core_top.i_control_unit.i_rv_core_properties.failures == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("%0d assertion failures",
                     i_rv_core_top.i_control_unit.i_rv_core_properties.failures);
            $display("Simulation finished: FAIL");
            $fatal(1, "assertion failures");
        end
    end

endmodule

/* all.f */
logic/rv_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/control_unit.sv
logic/datapath.sv
logic/memory_arbiter.sv
logic/unified_memory.sv
logic/rv_core_top.sv
verification/rv_core_properties.sv
verification/rv_core_tb.sv
